// File: Makefile
TOP = tile_layer_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f --Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: logic/tile_layer_top.sv
// --------------------
// Tile layer top: host routing, register bank, decoder,
// tile map RAM and pixel pipeline
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module tile_layer_top
  import tile_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  host_wr_t  host_wr,
  input  pix_req_t  pix_req,
  output logic      req_credit,
  output pix_out_t  pix_out,
  input  logic      out_credit
);

  host_wr_t                       reg_wr;
  logic                           map_wr_en;
  logic [`TILE_ALL_REG_BITS-1:0]  reg_values;
  logic [`TILE_LAYER_W-1:0]       cfg_layer;
  tile_layer_cfg_t                cfg;
  logic [`TILE_RAM_ADDR_W-1:0]    rd_addr;
  logic [`TILE_REG_WIDTH-1:0]     rd_data;

  // Register writes keep their enable only when aimed at the registers
  always_comb begin
    reg_wr    = host_wr;
    reg_wr.en = host_wr.en && (host_wr.target == HOST_REGS);
  end

  // Map writes use the host address as the RAM word address
  assign map_wr_en = host_wr.en && (host_wr.target == HOST_MAP);

  tile_reg_bank u_reg_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_wr    (reg_wr),
    .reg_values (reg_values)
  );

  tile_reg_decoder u_reg_decoder (
    .layer      (cfg_layer),
    .reg_values (reg_values),
    .cfg        (cfg)
  );

  tile_map_ram u_map_ram (
    .clk     (clk),
    .wr_en   (map_wr_en),
    .wr_addr (host_wr.addr),
    .wr_data (host_wr.data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  tile_pixel_pipe u_pixel_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_req    (pix_req),
    .req_credit (req_credit),
    .cfg_layer  (cfg_layer),
    .cfg        (cfg),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .pix_out    (pix_out),
    .out_credit (out_credit)
  );

endmodule

`default_nettype wire

// File: logic/tile_map_ram.sv
// --------------------
// Tile map memory, one write port and one registered read port
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module tile_map_ram (
  input  logic                         clk,
  input  logic                         wr_en,
  input  logic [`TILE_RAM_ADDR_W-1:0]  wr_addr,
  input  logic [`TILE_REG_WIDTH-1:0]   wr_data,
  input  logic [`TILE_RAM_ADDR_W-1:0]  rd_addr,
  output logic [`TILE_REG_WIDTH-1:0]   rd_data
);

  localparam int DEPTH = 1 << `TILE_RAM_ADDR_W;

  // Map entries, one tile value per word
  logic [`TILE_REG_WIDTH-1:0] mem [DEPTH];

  // Host side write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data follows the address by one cycle
  // A read of the address being written in the same cycle sees the old word
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: logic/tile_params.svh
// --------------------
// Tile layer sizing macros: layers, registers, map geometry,
// RAM depth, FIFO depth and credit limits
// --------------------
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// Four layers of seven 16-bit registers each
`define TILE_NUM_LAYERS   4
`define TILE_LAYER_W      2
`define TILE_NUM_REGS     7
`define TILE_REG_WIDTH    16

// Host register address is layer * 8 + register index
`define TILE_REG_IDX_W    3

// Flat width of the whole register bank
`define TILE_ALL_REG_BITS (`TILE_NUM_LAYERS * `TILE_NUM_REGS * `TILE_REG_WIDTH)

// Map is 32 by 32 tiles of 8 by 8 pixels
`define TILE_MAP_COLS     32
`define TILE_MAP_ROWS     32
`define TILE_SIZE_LOG2    3
`define TILE_COORD_W      16

// Tile map RAM holds 4096 words
`define TILE_RAM_ADDR_W   12

// FIFO depth doubles as the initial request credit count
`define TILE_FIFO_DEPTH   4
`define TILE_OUT_CREDIT_W 4
`define TILE_OUT_CREDIT_MAX 15

`endif

// File: logic/tile_pixel_pipe.sv
// --------------------
// Coordinate to tile-pixel pipeline with result FIFO
// and request and result credit counters
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module tile_pixel_pipe
  import tile_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  pix_req_t                     pix_req,
  output logic                         req_credit,
  output logic [`TILE_LAYER_W-1:0]     cfg_layer,
  input  tile_layer_cfg_t              cfg,
  output logic [`TILE_RAM_ADDR_W-1:0]  rd_addr,
  input  logic [`TILE_REG_WIDTH-1:0]   rd_data,
  output pix_out_t                     pix_out,
  input  logic                         out_credit
);

  localparam int COORD_W   = `TILE_COORD_W;
  localparam int COL_SHIFT = $clog2(`TILE_MAP_COLS);
  localparam int PTR_W     = $clog2(`TILE_FIFO_DEPTH);
  localparam int CNT_W     = $clog2(`TILE_FIFO_DEPTH + 1);
  // Map size in pixels, 256 on each axis
  localparam logic [COORD_W-1:0] MAP_W_PIX = COORD_W'(`TILE_MAP_COLS << `TILE_SIZE_LOG2);
  localparam logic [COORD_W-1:0] MAP_H_PIX = COORD_W'(`TILE_MAP_ROWS << `TILE_SIZE_LOG2);

  logic [COORD_W-1:0] map_x, map_y;
  logic [COORD_W-1:0] wrap_x, wrap_y;
  logic               oor_x, oor_y;
  logic [COORD_W-1:0] tile_col, tile_row;
  logic [COORD_W-1:0] addr_full;

  pipe_s1_t s1;
  pix_out_t s2, s2_next;

  pix_out_t              fifo_mem [`TILE_FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr, rd_ptr;
  logic [CNT_W-1:0]      fifo_count;
  logic                  push, pop;

  logic [`TILE_OUT_CREDIT_W-1:0] out_credits;
  // Credits currently held by the requester
  logic [CNT_W-1:0]              req_owned;

  // The decoder looks at the layer of the request being accepted
  assign cfg_layer = pix_req.layer;

  always_comb begin
    // Scroll adds the layer offset, wrapping at 2^16
    map_x = cfg.enable_scroll ? pix_req.x + cfg.offset_x : pix_req.x;
    map_y = cfg.enable_scroll ? pix_req.y + cfg.offset_y : pix_req.y;
    // Wrap folds into the map, otherwise anything past the edge is off-map
    wrap_x = cfg.enable_wrap_x ? (map_x & (MAP_W_PIX - 1'b1)) : map_x;
    wrap_y = cfg.enable_wrap_y ? (map_y & (MAP_H_PIX - 1'b1)) : map_y;
    oor_x  = !cfg.enable_wrap_x && (map_x >= MAP_W_PIX);
    oor_y  = !cfg.enable_wrap_y && (map_y >= MAP_H_PIX);
    tile_col  = wrap_x >> `TILE_SIZE_LOG2;
    tile_row  = wrap_y >> `TILE_SIZE_LOG2;
    addr_full = cfg.data_offset + (tile_row << COL_SHIFT) + tile_col;
  end

  // Address goes straight to the RAM, data returns alongside stage 1
  assign rd_addr = addr_full[`TILE_RAM_ADDR_W-1:0];

  // Stage 1 samples the config in the request's first cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1.valid <= 1'b0;
    end else begin
      s1.valid         <= pix_req.valid;
      s1.tag           <= pix_req.tag;
      s1.hidden        <= !cfg.layer_enabled || oor_x || oor_y;
      s1.enable_nop    <= cfg.enable_nop;
      s1.enable_transp <= cfg.enable_transp;
      s1.enable_flip   <= cfg.enable_flip;
      s1.nop_value     <= cfg.nop_value;
      s1.color_key     <= cfg.color_key;
      s1.px            <= wrap_x[`TILE_SIZE_LOG2-1:0];
      s1.py            <= wrap_y[`TILE_SIZE_LOG2-1:0];
      s1.alpha         <= cfg.enable_alpha ? cfg.ctrl1[7:0] : 8'hff;
    end
  end

  always_comb begin
    s2_next.valid       = s1.valid;
    s2_next.tag         = s1.tag;
    s2_next.tile_value  = rd_data;
    s2_next.transparent = s1.hidden ||
                          (s1.enable_nop && rd_data == s1.nop_value) ||
                          (s1.enable_transp && rd_data == s1.color_key);
    // Bit 15 of the map entry asks for a horizontal mirror
    s2_next.px          = (s1.enable_flip && rd_data[15]) ? 3'd7 - s1.px : s1.px;
    s2_next.py          = s1.py;
    s2_next.alpha       = s1.alpha;
  end

  // Stage 2 holds the finished result until it is pushed
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2.valid <= 1'b0;
    end else begin
      s2 <= s2_next;
    end
  end

  assign push = s2.valid;
  assign pop  = (fifo_count != '0) && (out_credits != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= s2;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: fifo_count <= fifo_count;
      endcase
    end
  end

  // Each pop shows one result for one cycle and hands one credit back
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_out.valid <= 1'b0;
      req_credit    <= 1'b0;
    end else begin
      if (pop) begin
        pix_out       <= fifo_mem[rd_ptr];
        pix_out.valid <= 1'b1;
      end else begin
        pix_out.valid <= 1'b0;
      end
      req_credit <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_credits <= '0;
      req_owned   <= CNT_W'(`TILE_FIFO_DEPTH);
    end else begin
      case ({out_credit, pop})
        2'b10:   out_credits <= out_credits + 1'b1;
        2'b01:   out_credits <= out_credits - 1'b1;
        default: out_credits <= out_credits;
      endcase
      case ({pix_req.valid, req_credit})
        2'b10:   req_owned <= req_owned - 1'b1;
        2'b01:   req_owned <= req_owned + 1'b1;
        default: req_owned <= req_owned;
      endcase
    end
  end

  // A request without a credit could land on a full FIFO two cycles later
  a_req_has_credit : assert property (
    @(posedge clk) disable iff (!rst_n)
    pix_req.valid |-> (req_owned != '0)
  );

  // The consumer never grants more than 15 unspent credits
  a_out_credit_max : assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_credit && !pop) |-> (out_credits < `TILE_OUT_CREDIT_MAX)
  );

endmodule

`default_nettype wire

// File: logic/tile_pkg.sv
// --------------------
// Register index and host target enums, host write, layer
// configuration, pixel request and pixel result structs
// --------------------
`default_nettype none

`include "tile_params.svh"

package tile_pkg;

  // Register index within one layer
  typedef enum logic [`TILE_REG_IDX_W-1:0] {
    CTRL0       = 3'd0,
    CTRL1       = 3'd1,
    DATA_OFFSET = 3'd2,
    NOP_VALUE   = 3'd3,
    COLOR_KEY   = 3'd4,
    OFFSET_X    = 3'd5,
    OFFSET_Y    = 3'd6
  } tile_reg_e;

  // Destination of one host write
  typedef enum logic {
    HOST_REGS = 1'b0,
    HOST_MAP  = 1'b1
  } host_target_e;

  typedef struct packed {
    logic                         en;
    host_target_e                 target;
    logic [`TILE_RAM_ADDR_W-1:0]  addr;
    logic [`TILE_REG_WIDTH-1:0]   data;
  } host_wr_t;

  // Decoded fields of the selected layer, CTRL0 bits 0 to 9 first
  typedef struct packed {
    logic layer_enabled;
    logic enable_8bit;
    logic enable_nop;
    logic enable_scroll;
    logic enable_transp;
    logic enable_alpha;
    logic enable_color;
    logic enable_wrap_x;
    logic enable_wrap_y;
    logic enable_flip;
    logic [`TILE_REG_WIDTH-1:0] ctrl1;
    logic [`TILE_REG_WIDTH-1:0] data_offset;
    logic [`TILE_REG_WIDTH-1:0] nop_value;
    logic [`TILE_REG_WIDTH-1:0] color_key;
    logic [`TILE_REG_WIDTH-1:0] offset_x;
    logic [`TILE_REG_WIDTH-1:0] offset_y;
  } tile_layer_cfg_t;

  typedef struct packed {
    logic                      valid;
    logic [`TILE_LAYER_W-1:0]  layer;
    logic [`TILE_COORD_W-1:0]  x;
    logic [`TILE_COORD_W-1:0]  y;
    logic [7:0]                tag;
  } pix_req_t;

  typedef struct packed {
    logic                        valid;
    logic [7:0]                  tag;
    logic                        transparent;
    logic [`TILE_REG_WIDTH-1:0]  tile_value;
    logic [`TILE_SIZE_LOG2-1:0]  px;
    logic [`TILE_SIZE_LOG2-1:0]  py;
    logic [7:0]                  alpha;
  } pix_out_t;

  // Stage 1 of the pixel pipe, holding what stage 2 needs from the config
  typedef struct packed {
    logic                        valid;
    logic [7:0]                  tag;
    logic                        hidden;
    logic                        enable_nop;
    logic                        enable_transp;
    logic                        enable_flip;
    logic [`TILE_REG_WIDTH-1:0]  nop_value;
    logic [`TILE_REG_WIDTH-1:0]  color_key;
    logic [`TILE_SIZE_LOG2-1:0]  px;
    logic [`TILE_SIZE_LOG2-1:0]  py;
    logic [7:0]                  alpha;
  } pipe_s1_t;

endpackage

`default_nettype wire

// File: logic/tile_reg_bank.sv
// --------------------
// Per-layer tile register storage written by the host
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module tile_reg_bank
  import tile_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  host_wr_t                      host_wr,
  output logic [`TILE_ALL_REG_BITS-1:0] reg_values
);

  // One 16-bit register per layer and index
  logic [`TILE_REG_WIDTH-1:0] regs [`TILE_NUM_LAYERS][`TILE_NUM_REGS];

  logic [`TILE_REG_IDX_W-1:0] wr_idx;
  logic [`TILE_LAYER_W-1:0]   wr_layer;
  logic                       wr_hit;

  // Low address bits pick the register, the next bits pick the layer
  assign wr_idx   = host_wr.addr[`TILE_REG_IDX_W-1:0];
  assign wr_layer = host_wr.addr[`TILE_REG_IDX_W +: `TILE_LAYER_W];

  // Index 7 is a hole in each layer's address window and is dropped
  assign wr_hit = host_wr.en && (host_wr.target == HOST_REGS) &&
                  (wr_idx < `TILE_REG_IDX_W'(`TILE_NUM_REGS));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int l = 0; l < `TILE_NUM_LAYERS; l++) begin
        for (int r = 0; r < `TILE_NUM_REGS; r++) begin
          regs[l][r] <= '0;
        end
      end
    end else if (wr_hit) begin
      regs[wr_layer][wr_idx] <= host_wr.data;
    end
  end

  // Flatten layer by layer, register 0 of layer 0 in the low bits
  for (genvar l = 0; l < `TILE_NUM_LAYERS; l++) begin : g_layer
    for (genvar r = 0; r < `TILE_NUM_REGS; r++) begin : g_reg
      assign reg_values[(l * `TILE_NUM_REGS + r) * `TILE_REG_WIDTH +: `TILE_REG_WIDTH] =
          regs[l][r];
    end
  end

  // The host never aims a register write past the last layer
  a_reg_layer_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    (host_wr.en && host_wr.target == HOST_REGS) |->
      ((host_wr.addr >> `TILE_REG_IDX_W) < `TILE_NUM_LAYERS)
  );

endmodule

`default_nettype wire

// File: logic/tile_reg_decoder.sv
// --------------------
// Layer select and register field decode
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module tile_reg_decoder
  import tile_pkg::*;
(
  input  logic [`TILE_LAYER_W-1:0]      layer,
  input  logic [`TILE_ALL_REG_BITS-1:0] reg_values,
  output tile_layer_cfg_t               cfg
);

  // Registers of every layer, unpacked from the flat bank vector
  logic [`TILE_REG_WIDTH-1:0] layer_regs [`TILE_NUM_LAYERS][`TILE_NUM_REGS];
  // Registers of the selected layer only
  logic [`TILE_REG_WIDTH-1:0] sel [`TILE_NUM_REGS];

  for (genvar l = 0; l < `TILE_NUM_LAYERS; l++) begin : g_layer
    for (genvar r = 0; r < `TILE_NUM_REGS; r++) begin : g_reg
      assign layer_regs[l][r] =
          reg_values[(l * `TILE_NUM_REGS + r) * `TILE_REG_WIDTH +: `TILE_REG_WIDTH];
    end
  end

  for (genvar r = 0; r < `TILE_NUM_REGS; r++) begin : g_sel
    assign sel[r] = layer_regs[layer][r];
  end

  always_comb begin
    // Enable flags sit in CTRL0 bits 0 to 9
    cfg.layer_enabled = sel[CTRL0][0];
    cfg.enable_8bit   = sel[CTRL0][1];
    cfg.enable_nop    = sel[CTRL0][2];
    cfg.enable_scroll = sel[CTRL0][3];
    cfg.enable_transp = sel[CTRL0][4];
    cfg.enable_alpha  = sel[CTRL0][5];
    cfg.enable_color  = sel[CTRL0][6];
    cfg.enable_wrap_x = sel[CTRL0][7];
    cfg.enable_wrap_y = sel[CTRL0][8];
    cfg.enable_flip   = sel[CTRL0][9];
    // Whole-register fields
    cfg.ctrl1         = sel[CTRL1];
    cfg.data_offset   = sel[DATA_OFFSET];
    cfg.nop_value     = sel[NOP_VALUE];
    cfg.color_key     = sel[COLOR_KEY];
    cfg.offset_x      = sel[OFFSET_X];
    cfg.offset_y      = sel[OFFSET_Y];
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/tile_pkg.sv
logic/tile_reg_bank.sv
logic/tile_reg_decoder.sv
logic/tile_map_ram.sv
logic/tile_pixel_pipe.sv
logic/tile_layer_top.sv
tests/tile_layer_tb.sv

// File: tests/tile_layer_tb.sv
// --------------------
// Directed testbench for the tile layer with reference model,
// result monitor, test tasks and watchdog
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "tile_params.svh"

module tile_layer_tb
  import tile_pkg::*;
();

  // The map fill takes 4096 cycles and the other tests stay under 2000, so this is a wide margin
  localparam int WATCHDOG_CYCLES = 20000;
  localparam int DRAIN_LIMIT     = 500;

  logic     clk;
  logic     rst_n;
  host_wr_t host_wr;
  pix_req_t pix_req;
  logic     req_credit;
  pix_out_t pix_out;
  logic     out_credit;

  // Shadow copies of what the host has written
  logic [15:0] shadow_regs [`TILE_NUM_LAYERS][`TILE_NUM_REGS];
  logic [15:0] shadow_map [1 << `TILE_RAM_ADDR_W];

  pix_out_t expected_q [$];
  pix_out_t actual_q [$];
  // sent and grants belong to the stimulus process, returned and n_recv to the monitor
  int       sent = 0;
  int       grants = 0;
  int       returned = 0;
  int       n_recv = 0;
  int       errors = 0;
  int       checks = 0;
  int       tests_run = 0;
  int       errors_at_start;
  int       checks_at_start;
  logic     auto_credit = 1'b1;
  logic [7:0] next_tag = 8'd0;
  string    cur_test;

  tile_layer_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_wr    (host_wr),
    .pix_req    (pix_req),
    .req_credit (req_credit),
    .pix_out    (pix_out),
    .out_credit (out_credit)
  );

  always #5 clk = ~clk;

  // DUT outputs change just after the rising edge and are stable at the falling edge
  always @(negedge clk) begin
    if (pix_out.valid === 1'b1) begin
      actual_q.push_back(pix_out);
      n_recv++;
    end
    if (req_credit === 1'b1) begin
      returned++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // Expected result of one request, from scroll, wrap, map lookup and the pixel rules
  function automatic pix_out_t model_pixel(input pix_req_t r);
    pix_out_t    o;
    logic [15:0] c0;
    logic [15:0] mx;
    logic [15:0] my;
    logic [15:0] v;
    logic [11:0] addr;
    logic        oor;
    c0  = shadow_regs[r.layer][CTRL0];
    mx  = c0[3] ? r.x + shadow_regs[r.layer][OFFSET_X] : r.x;
    my  = c0[3] ? r.y + shadow_regs[r.layer][OFFSET_Y] : r.y;
    oor = (!c0[7] && mx >= 16'd256) || (!c0[8] && my >= 16'd256);
    if (c0[7]) mx = mx % 16'd256;
    if (c0[8]) my = my % 16'd256;
    addr = 12'(shadow_regs[r.layer][DATA_OFFSET] + (my / 8) * 32 + mx / 8);
    v = shadow_map[addr];
    o.valid       = 1'b1;
    o.tag         = r.tag;
    o.tile_value  = v;
    o.transparent = !c0[0] || oor || (c0[2] && v == shadow_regs[r.layer][NOP_VALUE]) ||
                    (c0[4] && v == shadow_regs[r.layer][COLOR_KEY]);
    o.px          = (c0[9] && v[15]) ? 3'd7 - mx[2:0] : mx[2:0];
    o.py          = my[2:0];
    o.alpha       = c0[5] ? shadow_regs[r.layer][CTRL1][7:0] : 8'hff;
    return o;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error in %s (%s): expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
    end
  endtask

  // One clock step; strobes drop unless the caller drives them again after the edge
  task automatic tick();
    @(posedge clk);
    host_wr.en    <= 1'b0;
    pix_req.valid <= 1'b0;
    if (auto_credit && grants < sent) begin
      out_credit <= 1'b1;
      grants++;
    end else begin
      out_credit <= 1'b0;
    end
  endtask

  task automatic host_write(input host_target_e target, input logic [11:0] addr,
                            input logic [15:0] data);
    tick();
    host_wr <= '{en: 1'b1, target: target, addr: addr, data: data};
    if (target == HOST_MAP) begin
      shadow_map[addr] = data;
    end else if (addr[2:0] < 3'd7) begin
      shadow_regs[addr[4:3]][addr[2:0]] = data;
    end
  endtask

  task automatic reg_write(input logic [1:0] layer, input tile_reg_e idx, input logic [15:0] data);
    host_write(HOST_REGS, {7'd0, layer, idx}, data);
  endtask

  // Waits for a request credit, then issues one request and queues its expected result
  task automatic issue_req(input logic [1:0] layer, input logic [15:0] x, input logic [15:0] y);
    pix_req_t r;
    while (sent - returned >= `TILE_FIFO_DEPTH) tick();
    r = '{valid: 1'b1, layer: layer, x: x, y: y, tag: next_tag};
    next_tag++;
    tick();
    pix_req <= r;
    sent++;
    expected_q.push_back(model_pixel(r));
  endtask

  task automatic compare_results();
    pix_out_t exp_r;
    pix_out_t act_r;
    while (expected_q.size() > 0 && actual_q.size() > 0) begin
      exp_r = expected_q.pop_front();
      act_r = actual_q.pop_front();
      check_value($sformatf("tag %0d", exp_r.tag), 64'(exp_r), 64'(act_r));
    end
    if (expected_q.size() != actual_q.size()) begin
      errors++;
      $display("%s: %0d expected and %0d received results were left unmatched",
               cur_test, expected_q.size(), actual_q.size());
    end
    expected_q.delete();
    actual_q.delete();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (n_recv < sent && waited < DRAIN_LIMIT) begin
      tick();
      waited++;
    end
    if (n_recv < sent) begin
      errors++;
      $display("%s: gave up waiting for %0d missing results", cur_test, sent - n_recv);
    end
    compare_results();
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
    checks_at_start = checks;
  endtask

  task automatic end_test();
    tests_run++;
    $display("%s finished: %0d checks, %0d errors", cur_test, checks - checks_at_start,
             errors - errors_at_start);
  endtask

  task automatic test_reset();
    begin_test("reset_state");
    repeat (20) tick();
    check_value("results after reset", 0, 64'(n_recv));
    check_value("credit pulses after reset", 0, 64'(returned));
    // All registers are zero, so layer 0 is disabled and reads map word 0
    host_write(HOST_MAP, 12'd0, 16'($urandom));
    issue_req(2'd0, 16'd5, 16'd3);
    drain();
    end_test();
  endtask

  task automatic test_layer_decode();
    logic [15:0] ctrl0_tab [4] = '{16'h0001, 16'h0021, 16'h0181, 16'h0020};
    begin_test("layer_decode");
    for (int a = 0; a < (1 << `TILE_RAM_ADDR_W); a++) host_write(HOST_MAP, 12'(a), 16'($urandom));
    for (int l = 0; l < `TILE_NUM_LAYERS; l++) begin
      reg_write(2'(l), CTRL0, ctrl0_tab[l]);
      reg_write(2'(l), DATA_OFFSET, 16'(l * 16'h0410));
      reg_write(2'(l), CTRL1, 16'($urandom));
    end
    for (int i = 0; i < 24; i++) begin
      issue_req(2'($urandom_range(3, 0)), 16'($urandom_range(255, 0)),
                16'($urandom_range(255, 0)));
    end
    drain();
    end_test();
  endtask

  task automatic test_scroll_wrap();
    begin_test("scroll_wrap");
    // Offsets just below 256 push small screen coordinates past the map edge
    reg_write(2'd0, OFFSET_X, 16'd250);
    reg_write(2'd0, OFFSET_Y, 16'd252);
    reg_write(2'd0, CTRL0, 16'h0189);
    issue_req(2'd0, 16'd10, 16'd9);
    issue_req(2'd0, 16'd3, 16'd2);
    issue_req(2'd0, 16'd2, 16'd20);
    drain();
    // Wrap on y only, so x = 260 is off the map
    reg_write(2'd0, CTRL0, 16'h0109);
    issue_req(2'd0, 16'd10, 16'd9);
    issue_req(2'd0, 16'd3, 16'd9);
    drain();
    // Wrap on x only
    reg_write(2'd0, CTRL0, 16'h0089);
    issue_req(2'd0, 16'd3, 16'd9);
    issue_req(2'd0, 16'd10, 16'd2);
    drain();
    // Scroll off, so the offsets are ignored and both pixels stay on the map
    reg_write(2'd0, CTRL0, 16'h0001);
    issue_req(2'd0, 16'd10, 16'd9);
    issue_req(2'd0, 16'd250, 16'd3);
    drain();
    end_test();
  endtask

  task automatic test_nop_key_flip();
    logic [15:0] ctrl_tab [3] = '{16'h0205, 16'h0211, 16'h0001};
    begin_test("nop_key_flip");
    reg_write(2'd1, DATA_OFFSET, 16'h0400);
    reg_write(2'd1, NOP_VALUE, 16'h1234);
    reg_write(2'd1, COLOR_KEY, 16'h8abc);
    host_write(HOST_MAP, 12'h400, 16'h1234);
    host_write(HOST_MAP, 12'h401, 16'h8abc);
    host_write(HOST_MAP, 12'h402, 16'h8001);
    host_write(HOST_MAP, 12'h403, 16'h0002);
    // No-op only with flip, colour key only with flip, then neither
    for (int c = 0; c < 3; c++) begin
      reg_write(2'd1, CTRL0, ctrl_tab[c]);
      for (int k = 0; k < 4; k++) issue_req(2'd1, 16'(k * 8 + 2), 16'd5);
      drain();
    end
    end_test();
  endtask

  task automatic test_credit_flow();
    int base;
    int waited;
    begin_test("credit_flow");
    auto_credit = 1'b0;
    base = n_recv;
    for (int i = 0; i < `TILE_FIFO_DEPTH; i++) issue_req(2'd2, 16'(i * 9), 16'(i * 5));
    repeat (20) tick();
    check_value("results without credit", 64'(base), 64'(n_recv));
    check_value("requester credits left", 0, 64'(`TILE_FIFO_DEPTH - (sent - returned)));
    // Each granted credit must release exactly one result
    for (int i = 0; i < `TILE_FIFO_DEPTH; i++) begin
      base = n_recv;
      tick();
      out_credit <= 1'b1;
      grants++;
      waited = 0;
      while (n_recv == base && waited < 20) begin
        tick();
        waited++;
      end
      repeat (6) tick();
      check_value("results per credit", 64'(base + 1), 64'(n_recv));
    end
    check_value("request credits returned", 64'(sent), 64'(returned));
    compare_results();
    auto_credit = 1'b1;
    for (int i = 0; i < 40; i++) begin
      issue_req(2'($urandom_range(3, 0)), 16'($urandom_range(511, 0)),
                16'($urandom_range(511, 0)));
    end
    drain();
    end_test();
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    host_wr    = '0;
    pix_req    = '0;
    out_credit = 1'b0;
    void'($urandom(32'hf71f_acb5));
    for (int l = 0; l < `TILE_NUM_LAYERS; l++) begin
      for (int r = 0; r < `TILE_NUM_REGS; r++) shadow_regs[l][r] = '0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_layer_decode();
    test_scroll_wrap();
    test_nop_key_flip();
    test_credit_flow();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
